//--- Bender.yml
package:
  name: adder_unit

sources:
  - adder_pkg.sv
  - issue_buffer.sv
  - phys_regfile.sv
  - adder_issue.sv
  - adder_execute.sv
  - adder_unit.sv
  - target: test
    files:
      - tb_adder_unit.sv

//--- adder_execute.sv
// adder execute stage
`timescale 1ns/1ps

module adder_execute import adder_pkg::*; (
	input  logic     CLK,
	input  logic     rst,

	input  logic     issue_valid,
	input  logic     issue_sub,
	input  logic     issue_w,
	input  reg_idx_t issue_rd,
	input  xdata_t   issue_op1,
	input  xdata_t   issue_op2,

	output logic     wb_valid,
	output reg_idx_t wb_rd,
	output xdata_t   wb_data
);

	xdata_t operand_b;
	xdata_t sum;
	xdata_t result;

	// subtract as op1 + ~op2 + 1
	assign operand_b = issue_sub ? ~issue_op2 : issue_op2;
	assign sum       = issue_op1 + operand_b + xdata_t'(issue_sub);

	// w forms keep the low word, sign-extended
	assign result = issue_w ? {{(XLEN - 32){sum[31]}}, sum[31:0]} : sum;

	always_ff @(posedge CLK) begin
		if (rst) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= issue_valid;
		end
	end

	always_ff @(posedge CLK) begin
		if (issue_valid) begin
			wb_rd   <= issue_rd;
			wb_data <= result;
		end
	end

endmodule

//--- adder_issue.sv
// adder dispatch, select and operand read
`timescale 1ns/1ps

module adder_issue import adder_pkg::*; (
	input  logic                   CLK,
	input  logic                   rst,

	input  logic                   dispatch_valid,
	output logic                   dispatch_ready,
	input  adder_op_t              dispatch_op,
	input  xdata_t                 dispatch_pc,
	input  xdata_t                 dispatch_imm,
	input  reg_idx_t               dispatch_rd,
	input  reg_idx_t               dispatch_rs1,
	input  reg_idx_t               dispatch_rs2,

	output logic                   push,
	output adder_op_t              push_op,
	output xdata_t                 push_pc,
	output xdata_t                 push_imm,
	output reg_idx_t               push_rd,
	output reg_idx_t               push_rs1,
	output reg_idx_t               push_rs2,
	output logic                   pop,
	output slot_idx_t              pop_index,

	input  logic                   full,
	input  logic [ISSUE_DEPTH-1:0] entry_valid,
	input  adder_op_t              entry_op  [ISSUE_DEPTH],
	input  xdata_t                 entry_pc  [ISSUE_DEPTH],
	input  xdata_t                 entry_imm [ISSUE_DEPTH],
	input  reg_idx_t               entry_rd  [ISSUE_DEPTH],
	input  reg_idx_t               entry_rs1 [ISSUE_DEPTH],
	input  reg_idx_t               entry_rs2 [ISSUE_DEPTH],
	input  logic                   rd_conflict,

	input  logic [ISSUE_DEPTH-1:0] rs1_busy,
	input  logic [ISSUE_DEPTH-1:0] rs2_busy,
	input  logic                   rd_busy,
	output logic                   set_busy,
	output reg_idx_t               set_rd,

	output reg_idx_t               read_rs1,
	output reg_idx_t               read_rs2,
	input  xdata_t                 read_data1,
	input  xdata_t                 read_data2,

	output logic                   issue_valid,
	output logic                   issue_sub,
	output logic                   issue_w,
	output reg_idx_t               issue_rd,
	output xdata_t                 issue_op1,
	output xdata_t                 issue_op2
);

	logic [ISSUE_DEPTH-1:0] entry_ready;
	adder_op_t              sel_op;

	// room, no WAW on a busy rd, no WAR against a waiting entry
	assign dispatch_ready = (!full || pop) && !rd_busy && !rd_conflict;
	assign push           = dispatch_valid && dispatch_ready;

	assign push_op  = dispatch_op;
	assign push_pc  = dispatch_pc;
	assign push_imm = dispatch_imm;
	assign push_rd  = dispatch_rd;
	assign push_rs1 = dispatch_rs1;
	assign push_rs2 = dispatch_rs2;

	assign set_busy = push;
	assign set_rd   = dispatch_rd;

	// a source equal to the entry's own rd was final at dispatch,
	// its busy bit belongs to this very entry
	always_comb begin
		for (int i = 0; i < ISSUE_DEPTH; i++) begin
			entry_ready[i] = entry_valid[i]
				&& (!op_uses_rs1(entry_op[i]) || !rs1_busy[i] || entry_rs1[i] == entry_rd[i])
				&& (!op_uses_rs2(entry_op[i]) || !rs2_busy[i] || entry_rs2[i] == entry_rd[i]);
		end
	end

	// lowest ready slot wins
	always_comb begin
		issue_valid = 1'b0;
		pop_index   = '0;
		for (int i = ISSUE_DEPTH - 1; i >= 0; i--) begin
			if (entry_ready[i]) begin
				issue_valid = 1'b1;
				pop_index   = slot_idx_t'(i);
			end
		end
	end

	// execute never stalls
	assign pop = issue_valid;

	assign sel_op   = entry_op[pop_index];
	assign read_rs1 = entry_rs1[pop_index];
	assign read_rs2 = entry_rs2[pop_index];

	always_comb begin
		case (sel_op)
			OP_LUI:   issue_op1 = '0;
			OP_AUIPC: issue_op1 = entry_pc[pop_index];
			default:  issue_op1 = read_data1;
		endcase
	end

	assign issue_op2 = op_uses_rs2(sel_op) ? read_data2 : entry_imm[pop_index];
	assign issue_sub = op_is_sub(sel_op);
	assign issue_w   = op_is_word(sel_op);
	assign issue_rd  = entry_rd[pop_index];

endmodule

//--- adder_pkg.sv
// adder path shared definitions
package adder_pkg;

	localparam int XLEN        = 64;
	localparam int NREG        = 32;
	localparam int ISSUE_DEPTH = 4;

	localparam int REG_IDX_W  = $clog2(NREG);
	localparam int SLOT_IDX_W = $clog2(ISSUE_DEPTH);

	// architectural register index
	typedef logic [REG_IDX_W-1:0] reg_idx_t;

	// issue buffer slot
	typedef logic [SLOT_IDX_W-1:0] slot_idx_t;

	// data or address word
	typedef logic [XLEN-1:0] xdata_t;

	typedef enum logic [2:0] {
		OP_LUI,
		OP_AUIPC,
		OP_ADDI,
		OP_ADDIW,
		OP_ADD,
		OP_ADDW,
		OP_SUB,
		OP_SUBW
	} adder_op_t;

	// lui and auipc take no register source
	function automatic logic op_uses_rs1(adder_op_t op);
		return (op != OP_LUI) && (op != OP_AUIPC);
	endfunction

	// only register-register forms read rs2
	function automatic logic op_uses_rs2(adder_op_t op);
		logic uses;
		uses = (op == OP_ADD) || (op == OP_ADDW) || (op == OP_SUB) || (op == OP_SUBW);
		return uses;
	endfunction

	function automatic logic op_is_sub(adder_op_t op);
		return (op == OP_SUB) || (op == OP_SUBW);
	endfunction

	// 32-bit result, sign-extended to XLEN
	function automatic logic op_is_word(adder_op_t op);
		logic word;
		word = (op == OP_ADDIW) || (op == OP_ADDW) || (op == OP_SUBW);
		return word;
	endfunction

endpackage

//--- adder_unit.sv
// adder unit top
`timescale 1ns/1ps

module adder_unit import adder_pkg::*; (
	input  logic      CLK,
	input  logic      rst,

	input  logic      dispatch_valid,
	output logic      dispatch_ready,
	input  adder_op_t dispatch_op,
	input  xdata_t    dispatch_pc,
	input  xdata_t    dispatch_imm,
	input  reg_idx_t  dispatch_rd,
	input  reg_idx_t  dispatch_rs1,
	input  reg_idx_t  dispatch_rs2,

	output logic      wb_valid,
	output reg_idx_t  wb_rd,
	output xdata_t    wb_data
);

	logic                   push;
	adder_op_t              push_op;
	xdata_t                 push_pc;
	xdata_t                 push_imm;
	reg_idx_t               push_rd;
	reg_idx_t               push_rs1;
	reg_idx_t               push_rs2;
	logic                   pop;
	slot_idx_t              pop_index;

	logic                   full;
	logic [ISSUE_DEPTH-1:0] entry_valid;
	adder_op_t              entry_op  [ISSUE_DEPTH];
	xdata_t                 entry_pc  [ISSUE_DEPTH];
	xdata_t                 entry_imm [ISSUE_DEPTH];
	reg_idx_t               entry_rd  [ISSUE_DEPTH];
	reg_idx_t               entry_rs1 [ISSUE_DEPTH];
	reg_idx_t               entry_rs2 [ISSUE_DEPTH];
	logic                   rd_conflict;

	logic [ISSUE_DEPTH-1:0] rs1_busy;
	logic [ISSUE_DEPTH-1:0] rs2_busy;
	logic                   rd_busy;
	logic                   set_busy;
	reg_idx_t               set_rd;
	reg_idx_t               read_rs1;
	reg_idx_t               read_rs2;
	xdata_t                 read_data1;
	xdata_t                 read_data2;

	logic                   issue_valid;
	logic                   issue_sub;
	logic                   issue_w;
	reg_idx_t               issue_rd;
	xdata_t                 issue_op1;
	xdata_t                 issue_op2;

	adder_issue u_issue (
		.CLK            (CLK),
		.rst            (rst),
		.dispatch_valid (dispatch_valid),
		.dispatch_ready (dispatch_ready),
		.dispatch_op    (dispatch_op),
		.dispatch_pc    (dispatch_pc),
		.dispatch_imm   (dispatch_imm),
		.dispatch_rd    (dispatch_rd),
		.dispatch_rs1   (dispatch_rs1),
		.dispatch_rs2   (dispatch_rs2),
		.push           (push),
		.push_op        (push_op),
		.push_pc        (push_pc),
		.push_imm       (push_imm),
		.push_rd        (push_rd),
		.push_rs1       (push_rs1),
		.push_rs2       (push_rs2),
		.pop            (pop),
		.pop_index      (pop_index),
		.full           (full),
		.entry_valid    (entry_valid),
		.entry_op       (entry_op),
		.entry_pc       (entry_pc),
		.entry_imm      (entry_imm),
		.entry_rd       (entry_rd),
		.entry_rs1      (entry_rs1),
		.entry_rs2      (entry_rs2),
		.rd_conflict    (rd_conflict),
		.rs1_busy       (rs1_busy),
		.rs2_busy       (rs2_busy),
		.rd_busy        (rd_busy),
		.set_busy       (set_busy),
		.set_rd         (set_rd),
		.read_rs1       (read_rs1),
		.read_rs2       (read_rs2),
		.read_data1     (read_data1),
		.read_data2     (read_data2),
		.issue_valid    (issue_valid),
		.issue_sub      (issue_sub),
		.issue_w        (issue_w),
		.issue_rd       (issue_rd),
		.issue_op1      (issue_op1),
		.issue_op2      (issue_op2)
	);

	issue_buffer u_buffer (
		.CLK         (CLK),
		.rst         (rst),
		.push        (push),
		.push_op     (push_op),
		.push_pc     (push_pc),
		.push_imm    (push_imm),
		.push_rd     (push_rd),
		.push_rs1    (push_rs1),
		.push_rs2    (push_rs2),
		.pop         (pop),
		.pop_index   (pop_index),
		.check_rd    (dispatch_rd),
		.full        (full),
		.entry_valid (entry_valid),
		.entry_op    (entry_op),
		.entry_pc    (entry_pc),
		.entry_imm   (entry_imm),
		.entry_rd    (entry_rd),
		.entry_rs1   (entry_rs1),
		.entry_rs2   (entry_rs2),
		.rd_conflict (rd_conflict)
	);

	phys_regfile u_regfile (
		.CLK        (CLK),
		.rst        (rst),
		.query_rs1  (entry_rs1),
		.query_rs2  (entry_rs2),
		.check_rd   (dispatch_rd),
		.read_rs1   (read_rs1),
		.read_rs2   (read_rs2),
		.set_busy   (set_busy),
		.set_rd     (set_rd),
		.wb_valid   (wb_valid),
		.wb_rd      (wb_rd),
		.wb_data    (wb_data),
		.rs1_busy   (rs1_busy),
		.rs2_busy   (rs2_busy),
		.rd_busy    (rd_busy),
		.read_data1 (read_data1),
		.read_data2 (read_data2)
	);

	adder_execute u_execute (
		.CLK         (CLK),
		.rst         (rst),
		.issue_valid (issue_valid),
		.issue_sub   (issue_sub),
		.issue_w     (issue_w),
		.issue_rd    (issue_rd),
		.issue_op1   (issue_op1),
		.issue_op2   (issue_op2),
		.wb_valid    (wb_valid),
		.wb_rd       (wb_rd),
		.wb_data     (wb_data)
	);

endmodule

//--- issue_buffer.sv
// adder issue buffer
`timescale 1ns/1ps

module issue_buffer import adder_pkg::*; (
	input  logic                   CLK,
	input  logic                   rst,

	input  logic                   push,
	input  adder_op_t              push_op,
	input  xdata_t                 push_pc,
	input  xdata_t                 push_imm,
	input  reg_idx_t               push_rd,
	input  reg_idx_t               push_rs1,
	input  reg_idx_t               push_rs2,

	input  logic                   pop,
	input  slot_idx_t              pop_index,

	input  reg_idx_t               check_rd,

	output logic                   full,
	output logic [ISSUE_DEPTH-1:0] entry_valid,
	output adder_op_t              entry_op  [ISSUE_DEPTH],
	output xdata_t                 entry_pc  [ISSUE_DEPTH],
	output xdata_t                 entry_imm [ISSUE_DEPTH],
	output reg_idx_t               entry_rd  [ISSUE_DEPTH],
	output reg_idx_t               entry_rs1 [ISSUE_DEPTH],
	output reg_idx_t               entry_rs2 [ISSUE_DEPTH],
	output logic                   rd_conflict
);

	logic [ISSUE_DEPTH-1:0] pop_mask;
	logic [ISSUE_DEPTH-1:0] free_mask;
	logic [ISSUE_DEPTH-1:0] valid_next;
	slot_idx_t              free_idx;

	assign full = &entry_valid;

	// a slot freed by this cycle's pop can be refilled at the same edge
	assign pop_mask  = pop ? (ISSUE_DEPTH'(1) << pop_index) : '0;
	assign free_mask = ~entry_valid | pop_mask;

	// lowest free slot
	always_comb begin
		free_idx = '0;
		for (int i = ISSUE_DEPTH - 1; i >= 0; i--) begin
			if (free_mask[i]) begin
				free_idx = slot_idx_t'(i);
			end
		end
	end

	always_comb begin
		valid_next = entry_valid & ~pop_mask;
		if (push) begin
			valid_next[free_idx] = 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			entry_valid <= '0;
		end else begin
			entry_valid <= valid_next;
		end
	end

	always_ff @(posedge CLK) begin
		if (push) begin
			entry_op[free_idx]  <= push_op;
			entry_pc[free_idx]  <= push_pc;
			entry_imm[free_idx] <= push_imm;
			entry_rd[free_idx]  <= push_rd;
			entry_rs1[free_idx] <= push_rs1;
			entry_rs2[free_idx] <= push_rs2;
		end
	end

	// WAR guard, only sources the op really reads count
	always_comb begin
		rd_conflict = 1'b0;
		for (int i = 0; i < ISSUE_DEPTH; i++) begin
			if (entry_valid[i] && check_rd != '0) begin
				if (op_uses_rs1(entry_op[i]) && entry_rs1[i] == check_rd) begin
					rd_conflict = 1'b1;
				end
				if (op_uses_rs2(entry_op[i]) && entry_rs2[i] == check_rd) begin
					rd_conflict = 1'b1;
				end
			end
		end
	end

endmodule

//--- list.f
adder_pkg.sv
issue_buffer.sv
phys_regfile.sv
adder_issue.sv
adder_execute.sv
adder_unit.sv
tb_adder_unit.sv

//--- phys_regfile.sv
// register file and busy scoreboard
`timescale 1ns/1ps

module phys_regfile import adder_pkg::*; (
	input  logic                   CLK,
	input  logic                   rst,

	input  reg_idx_t               query_rs1 [ISSUE_DEPTH],
	input  reg_idx_t               query_rs2 [ISSUE_DEPTH],
	input  reg_idx_t               check_rd,

	input  reg_idx_t               read_rs1,
	input  reg_idx_t               read_rs2,

	input  logic                   set_busy,
	input  reg_idx_t               set_rd,

	input  logic                   wb_valid,
	input  reg_idx_t               wb_rd,
	input  xdata_t                 wb_data,

	output logic [ISSUE_DEPTH-1:0] rs1_busy,
	output logic [ISSUE_DEPTH-1:0] rs2_busy,
	output logic                   rd_busy,
	output xdata_t                 read_data1,
	output xdata_t                 read_data2
);

	xdata_t            regs [NREG];
	logic [NREG-1:0]   busy;

	always_comb begin
		for (int i = 0; i < ISSUE_DEPTH; i++) begin
			rs1_busy[i] = busy[query_rs1[i]];
			rs2_busy[i] = busy[query_rs2[i]];
		end
	end

	assign rd_busy = busy[check_rd];

	// x0 is hardwired to zero
	assign read_data1 = (read_rs1 == '0) ? '0 : regs[read_rs1];
	assign read_data2 = (read_rs2 == '0) ? '0 : regs[read_rs2];

	always_ff @(posedge CLK) begin
		if (rst) begin
			for (int i = 0; i < NREG; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_valid && wb_rd != '0) begin
			regs[wb_rd] <= wb_data;
		end
	end

	// set comes last so it wins over a clear of the same register
	always_ff @(posedge CLK) begin
		if (rst) begin
			busy <= '0;
		end else begin
			if (wb_valid && wb_rd != '0) begin
				busy[wb_rd] <= 1'b0;
			end
			if (set_busy && set_rd != '0) begin
				busy[set_rd] <= 1'b1;
			end
		end
	end

endmodule

//--- tb_adder_unit.sv
// adder unit testbench
`timescale 1ns/1ps

module tb_adder_unit import adder_pkg::*;;

	localparam int PLANNED_INSTR  = 366;
	localparam int TIMEOUT_CYCLES = 40 * PLANNED_INSTR + 200;
	localparam int DRAIN_LIMIT    = 40 * (ISSUE_DEPTH + 1);
	localparam int MAX_TAGS       = 1024;

	logic      CLK;
	logic      rst;
	logic      dispatch_valid;
	logic      dispatch_ready;
	adder_op_t dispatch_op;
	xdata_t    dispatch_pc;
	xdata_t    dispatch_imm;
	reg_idx_t  dispatch_rd;
	reg_idx_t  dispatch_rs1;
	reg_idx_t  dispatch_rs2;
	logic      wb_valid;
	reg_idx_t  wb_rd;
	xdata_t    wb_data;

	// in-order reference state with one outstanding result per rd except x0
	xdata_t model_regs [NREG];
	xdata_t expected   [NREG];
	bit     pending    [NREG];
	int     tag_of     [NREG];
	int     dep1       [NREG];
	int     dep2       [NREG];
	bit     wb_done    [MAX_TAGS];
	xdata_t zero_expected [$];

	string  test_name;
	xdata_t next_pc;
	integer seed;
	int     errors;
	int     checks;
	int     dispatched;
	int     written;
	int     outstanding;
	int     cycles;

	adder_unit dut (
		.CLK            (CLK),
		.rst            (rst),
		.dispatch_valid (dispatch_valid),
		.dispatch_ready (dispatch_ready),
		.dispatch_op    (dispatch_op),
		.dispatch_pc    (dispatch_pc),
		.dispatch_imm   (dispatch_imm),
		.dispatch_rd    (dispatch_rd),
		.dispatch_rs1   (dispatch_rs1),
		.dispatch_rs2   (dispatch_rs2),
		.wb_valid       (wb_valid),
		.wb_rd          (wb_rd),
		.wb_data        (wb_data)
	);

	initial begin
		CLK = 1'b0;
	end

	always #2 CLK = ~CLK;

	function automatic bit reads_rs1(adder_op_t op);
		return !(op == OP_LUI || op == OP_AUIPC);
	endfunction

	function automatic bit reads_rs2(adder_op_t op);
		return op == OP_ADD || op == OP_ADDW || op == OP_SUB || op == OP_SUBW;
	endfunction

	function automatic xdata_t reference_result(adder_op_t op, xdata_t pc, xdata_t imm,
			xdata_t a, xdata_t b);
		xdata_t r;
		case (op)
			OP_LUI:            r = imm;
			OP_AUIPC:          r = pc + imm;
			OP_ADDI, OP_ADDIW: r = a + imm;
			OP_ADD, OP_ADDW:   r = a + b;
			default:           r = a - b;
		endcase
		// word forms keep bits 31:0 and sign-extend
		if (op == OP_ADDIW || op == OP_ADDW || op == OP_SUBW) begin
			r = {{32{r[31]}}, r[31:0]};
		end
		return r;
	endfunction

	// called on a falling edge, returns on the falling edge after the handshake
	task automatic dispatch_instr(input adder_op_t op, input reg_idx_t rd, input reg_idx_t rs1,
			input reg_idx_t rs2, input xdata_t imm, input bit expect_stall);
		bit     first;
		bit     accepted;
		xdata_t a;
		xdata_t b;
		first          = 1'b1;
		accepted       = 1'b0;
		dispatch_valid = 1'b1;
		dispatch_op    = op;
		dispatch_pc    = next_pc;
		dispatch_imm   = imm;
		dispatch_rd    = rd;
		dispatch_rs1   = rs1;
		dispatch_rs2   = rs2;
		while (!accepted) begin
			#1;
			if (first && expect_stall) begin
				checks++;
				assert (!dispatch_ready) else begin
					$display("ERROR %s: dispatch_ready expected 0 actual 1", test_name);
					errors++;
				end
			end
			first = 1'b0;
			if (dispatch_ready) begin
				accepted = 1'b1;
				a = (rs1 == '0) ? '0 : model_regs[rs1];
				b = (rs2 == '0) ? '0 : model_regs[rs2];
				if (rd == '0) begin
					zero_expected.push_back(reference_result(op, next_pc, imm, a, b));
				end else begin
					checks++;
					assert (!pending[rd]) else begin
						$display("instruction accepted while x%0d was still busy", rd);
						errors++;
					end
					dep1[rd] = (reads_rs1(op) && rs1 != '0 && pending[rs1]) ? tag_of[rs1] : -1;
					dep2[rd] = (reads_rs2(op) && rs2 != '0 && pending[rs2]) ? tag_of[rs2] : -1;
					model_regs[rd] = reference_result(op, next_pc, imm, a, b);
					expected[rd]   = model_regs[rd];
					pending[rd]    = 1'b1;
					tag_of[rd]     = dispatched;
				end
				dispatched++;
				outstanding++;
			end
			@(negedge CLK);
		end
		next_pc = next_pc + 4;
	endtask

	task automatic check_writeback(input reg_idx_t rd, input xdata_t data);
		int hit;
		hit = -1;
		checks++;
		if (rd == '0) begin
			// several x0 writes may be in flight and finish out of order
			foreach (zero_expected[i]) begin
				if (hit < 0 && zero_expected[i] === data) begin
					hit = i;
				end
			end
			assert (hit >= 0) else begin
				$display("ERROR %s: x0 expected %h actual %h", test_name,
					(zero_expected.size() > 0) ? zero_expected[0] : xdata_t'(0), data);
				errors++;
			end
			if (hit >= 0) begin
				zero_expected.delete(hit);
			end
		end else begin
			assert (pending[rd]) else begin
				$display("writeback to x%0d with no instruction outstanding", rd);
				errors++;
			end
			assert (data === expected[rd]) else begin
				$display("ERROR %s: x%0d expected %h actual %h", test_name, rd,
					expected[rd], data);
				errors++;
			end
			assert ((dep1[rd] < 0 || wb_done[dep1[rd]]) && (dep2[rd] < 0 || wb_done[dep2[rd]]))
			else begin
				$display("x%0d was written back before its producer", rd);
				errors++;
			end
			wb_done[tag_of[rd]] = 1'b1;
			pending[rd]         = 1'b0;
		end
		written++;
		outstanding--;
	endtask

	task automatic idle_cycles(input int n);
		dispatch_valid = 1'b0;
		repeat (n) @(negedge CLK);
	endtask

	// busy bits clear one edge after the last writeback is seen
	task automatic drain();
		int waited;
		dispatch_valid = 1'b0;
		waited         = 0;
		do begin
			@(negedge CLK);
			#1;
			waited++;
		end while (outstanding != 0 && waited < DRAIN_LIMIT);
		@(negedge CLK);
	endtask

	always @(negedge CLK) begin
		if (!rst && wb_valid) begin
			check_writeback(wb_rd, wb_data);
		end
	end

	always @(negedge CLK) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TEST FAILED");
			$finish;
		end
	end

	initial begin : main
		logic [31:0] rnd;
		seed        = 89242;
		errors      = 0;
		checks      = 0;
		dispatched  = 0;
		written     = 0;
		outstanding = 0;
		cycles      = 0;
		next_pc     = 64'h0000_0000_8000_0000;
		for (int i = 0; i < NREG; i++) begin
			model_regs[i] = '0;
			pending[i]    = 1'b0;
		end
		rst            = 1'b1;
		dispatch_valid = 1'b0;
		dispatch_op    = OP_ADD;
		dispatch_pc    = '0;
		dispatch_imm   = '0;
		dispatch_rd    = '0;
		dispatch_rs1   = '0;
		dispatch_rs2   = '0;
		test_name      = "reset";
		repeat (2) @(negedge CLK);
		rst = 1'b0;
		#1;
		checks++;
		assert (wb_valid === 1'b0 && dispatch_ready === 1'b1) else begin
			$display("unit not idle after reset");
			errors++;
		end
		@(negedge CLK);

		test_name = "arithmetic";
		dispatch_instr(OP_LUI, 5'd1, 5'd0, 5'd0, 64'h0000_0000_1234_5000, 1'b0);
		next_pc = 64'h0000_0000_8000_1000;
		dispatch_instr(OP_AUIPC, 5'd2, 5'd0, 5'd0, 64'hFFFF_FFFF_FFFF_F000, 1'b0);
		dispatch_instr(OP_ADDI, 5'd3, 5'd1, 5'd0, 64'hFFFF_FFFF_FFFF_FFFB, 1'b0);
		dispatch_instr(OP_ADD, 5'd4, 5'd1, 5'd2, 64'h0, 1'b0);
		dispatch_instr(OP_SUB, 5'd5, 5'd0, 5'd1, 64'h0, 1'b0);
		dispatch_instr(OP_SUB, 5'd6, 5'd3, 5'd2, 64'h0, 1'b0);
		drain();

		test_name = "word forms";
		dispatch_instr(OP_LUI, 5'd7, 5'd0, 5'd0, 64'h0000_0000_7FFF_F000, 1'b0);
		dispatch_instr(OP_ADDIW, 5'd8, 5'd7, 5'd0, 64'h0000_0000_0000_1000, 1'b0);
		dispatch_instr(OP_ADDW, 5'd9, 5'd7, 5'd7, 64'h0, 1'b0);
		dispatch_instr(OP_SUBW, 5'd10, 5'd8, 5'd7, 64'h0, 1'b0);
		dispatch_instr(OP_ADDIW, 5'd13, 5'd4, 5'd0, 64'h0000_0000_7FFF_FFFF, 1'b0);
		drain();

		test_name = "raw chain";
		dispatch_instr(OP_ADDI, 5'd21, 5'd0, 5'd0, 64'h7FFF_FFFF_FFFF_FFFF, 1'b0);
		dispatch_instr(OP_ADD, 5'd22, 5'd21, 5'd21, 64'h0, 1'b0);
		dispatch_instr(OP_ADDW, 5'd23, 5'd22, 5'd21, 64'h0, 1'b0);
		dispatch_instr(OP_SUB, 5'd24, 5'd23, 5'd22, 64'h0, 1'b0);
		dispatch_instr(OP_ADDIW, 5'd25, 5'd24, 5'd0, 64'hFFFF_FFFF_FFFF_FFFF, 1'b0);
		drain();

		// x14 arrives late, so E..H fill all four slots and I has to wait
		test_name = "out of order";
		dispatch_instr(OP_ADDI, 5'd11, 5'd0, 5'd0, 64'd5, 1'b0);
		dispatch_instr(OP_ADD, 5'd12, 5'd11, 5'd11, 64'h0, 1'b0);
		dispatch_instr(OP_ADD, 5'd13, 5'd12, 5'd12, 64'h0, 1'b0);
		dispatch_instr(OP_ADD, 5'd14, 5'd13, 5'd13, 64'h0, 1'b0);
		dispatch_instr(OP_ADD, 5'd15, 5'd14, 5'd0, 64'h0, 1'b0);
		dispatch_instr(OP_ADD, 5'd16, 5'd14, 5'd0, 64'h0, 1'b0);
		dispatch_instr(OP_ADD, 5'd17, 5'd14, 5'd0, 64'h0, 1'b0);
		dispatch_instr(OP_ADD, 5'd18, 5'd14, 5'd0, 64'h0, 1'b0);
		dispatch_instr(OP_ADD, 5'd19, 5'd14, 5'd0, 64'h0, 1'b1);
		dispatch_instr(OP_ADDI, 5'd20, 5'd0, 5'd0, 64'd77, 1'b0);
		drain();

		test_name = "hazard";
		dispatch_instr(OP_ADDI, 5'd5, 5'd0, 5'd0, 64'd7, 1'b0);
		dispatch_instr(OP_ADDI, 5'd5, 5'd0, 5'd0, 64'd9, 1'b1);
		drain();
		dispatch_instr(OP_ADDI, 5'd7, 5'd0, 5'd0, 64'd3, 1'b0);
		dispatch_instr(OP_ADD, 5'd8, 5'd7, 5'd6, 64'h0, 1'b0);
		dispatch_instr(OP_ADDI, 5'd6, 5'd0, 5'd0, 64'd1, 1'b1);
		drain();
		dispatch_instr(OP_ADDI, 5'd0, 5'd0, 5'd0, 64'd55, 1'b0);
		dispatch_instr(OP_ADD, 5'd0, 5'd5, 5'd5, 64'h0, 1'b0);
		dispatch_instr(OP_ADD, 5'd26, 5'd0, 5'd0, 64'h0, 1'b0);
		dispatch_instr(OP_SUB, 5'd27, 5'd5, 5'd0, 64'h0, 1'b0);
		drain();

		test_name = "random";
		for (int n = 0; n < 300; n++) begin
			rnd = $random(seed);
			dispatch_instr(adder_op_t'(rnd[2:0]), reg_idx_t'(rnd[10:8] % 6),
				reg_idx_t'(rnd[14:12] % 6), reg_idx_t'(rnd[18:16] % 6),
				{$random(seed), $random(seed)}, 1'b0);
			if (rnd[21:20] == 2'b00) begin
				idle_cycles(1 + rnd[23:22]);
			end
		end
		drain();

		// copying every register onto itself exposes the final state
		test_name = "readback";
		for (int r = 1; r < NREG; r++) begin
			dispatch_instr(OP_ADDI, reg_idx_t'(r), reg_idx_t'(r), 5'd0, 64'h0, 1'b0);
		end
		drain();

		checks++;
		assert (written == dispatched) else begin
			$display("lost instructions, %0d dispatched but %0d written back",
				dispatched, written);
			errors++;
		end
		$display("checks %0d, errors %0d, dispatched %0d, written back %0d",
			checks, errors, dispatched, written);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
